/* run.sh */
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module cache_system_tb -o cache_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0

/* src/cache_cfg_pkg.sv */
// geometry must agree with the address split in cpu_types_pkg; compile that package first
package cache_cfg_pkg;

	// cache organization
	localparam int DSETS = 8;
	localparam int DWAYS = 2;
	localparam int BLK_WORDS = 2;

	// memory side
	localparam int MEM_WAIT = 2;
	localparam int MEM_ADDR_W = 8;
	localparam int WAIT_CNT_W = $clog2(MEM_WAIT + 1);

	// one cache line with its state bits
	typedef struct packed {
		logic [cpu_types_pkg::DTAG_W-1:0] tag;
		cpu_types_pkg::word_t [BLK_WORDS-1:0] data;
		logic valid;
		logic dirty;
	} cache_block_t;

endpackage

/* src/cache_control_if.sv */
// single requester; the cache holds dREN or dWEN with a stable address until dwait falls
`timescale 1ns/10ps

interface cache_control_if;
	import cpu_types_pkg::*;

	// cache to memory
	logic dREN;
	logic dWEN;
	word_t daddr;
	word_t dstore;

	// memory to cache
	word_t dload;
	logic dwait;

	modport dcache (
		output dREN, dWEN, daddr, dstore,
		input dload, dwait
	);

	modport mem (
		input dREN, dWEN, daddr, dstore,
		output dload, dwait
	);

endinterface

/* src/cache_system.sv */
// one blocking data cache over a wait-state word memory; datapath ports follow the dhit handshake
`timescale 1ns/10ps

module cache_system (
	input logic CLK,
	input logic nRST,
	input logic dmemREN,
	input logic dmemWEN,
	input logic halt,
	input cpu_types_pkg::word_t dmemaddr,
	input cpu_types_pkg::word_t dmemstore,
	output cpu_types_pkg::word_t dmemload,
	output logic dhit,
	output logic flushed
);

	datapath_cache_if dcif ();
	cache_control_if ccif ();

	// datapath side onto the interface
	assign dcif.dmemREN = dmemREN;
	assign dcif.dmemWEN = dmemWEN;
	assign dcif.halt = halt;
	assign dcif.dmemaddr = dmemaddr;
	assign dcif.dmemstore = dmemstore;

	assign dmemload = dcif.dmemload;
	assign dhit = dcif.dhit;
	assign flushed = dcif.flushed;

	dcache u_dcache (
		.CLK(CLK),
		.nRST(nRST),
		.dcif(dcif.dcache),
		.ccif(ccif.dcache)
	);

	memory_control u_mem (
		.CLK(CLK),
		.nRST(nRST),
		.ccif(ccif.mem)
	);

endmodule

/* src/cpu_types_pkg.sv */
// byte addresses split for an 8-set, 2-word-block cache; sub-word accesses are not supported
package cpu_types_pkg;

	localparam int WORD_W = 32;

	// address field widths for the data cache
	localparam int DTAG_W = 26;
	localparam int DIDX_W = 3;
	localparam int DBLK_W = 1;
	localparam int DBYT_W = 2;

	typedef logic [WORD_W-1:0] word_t;

	// byte address as seen by the data cache
	typedef struct packed {
		logic [DTAG_W-1:0] tag;
		logic [DIDX_W-1:0] idx;
		logic [DBLK_W-1:0] blkoff;
		logic [DBYT_W-1:0] bytoff;
	} dcachef_t;

endpackage

/* src/datapath_cache_if.sv */
// level signalling only; the datapath holds a request until dhit and holds halt until flushed
`timescale 1ns/10ps

interface datapath_cache_if;
	import cpu_types_pkg::*;

	// requests from the datapath
	logic dmemREN;
	logic dmemWEN;
	logic halt;
	word_t dmemaddr;
	word_t dmemstore;

	// answers from the cache
	word_t dmemload;
	logic dhit;
	logic flushed;

	modport dp (
		output dmemREN, dmemWEN, halt, dmemaddr, dmemstore,
		input dmemload, dhit, flushed
	);

	modport dcache (
		input dmemREN, dmemWEN, halt, dmemaddr, dmemstore,
		output dmemload, dhit, flushed
	);

endinterface

/* src/dcache.sv */
// blocking 2-way write-back cache; flush counter layout assumes exactly two ways
`timescale 1ns/10ps

module dcache (
	input logic CLK,
	input logic nRST,
	datapath_cache_if.dcache dcif,
	cache_control_if.dcache ccif
);
	import cpu_types_pkg::*;
	import cache_cfg_pkg::*;

	typedef enum logic [2:0] {
		IDLE, WB1, WB2, FETCH1, FETCH2, FLUSH1, FLUSH2, FLUSHED
	} state_t;

	state_t state;
	state_t next_state;

	cache_block_t [DSETS-1:0][DWAYS-1:0] cache;
	// way most recently used, per set
	logic [DSETS-1:0] mru;
	// flush walk: high bit is the way, low bits the set
	logic [DIDX_W:0] fcnt;
	logic [DIDX_W:0] fcnt_next;

	dcachef_t req;
	logic req_valid;
	logic hit0;
	logic hit1;
	logic hit;
	logic hit_way;
	logic victim_way;
	cache_block_t victim;
	logic [DIDX_W-1:0] fset;
	logic fway;
	cache_block_t fblk;
	logic [DBLK_W-1:0] mem_blk;
	logic mem_done;
	logic last_block;

	assign req = dcachef_t'(dcif.dmemaddr);
	assign req_valid = dcif.dmemREN | dcif.dmemWEN;

	// tag compare on both ways
	assign hit0 = cache[req.idx][0].valid && (cache[req.idx][0].tag == req.tag);
	assign hit1 = cache[req.idx][1].valid && (cache[req.idx][1].tag == req.tag);
	assign hit = hit0 | hit1;
	assign hit_way = hit1;

	assign victim_way = ~mru[req.idx];
	assign victim = cache[req.idx][victim_way];

	assign fset = fcnt[DIDX_W-1:0];
	assign fway = fcnt[DIDX_W];
	assign fblk = cache[fset][fway];
	assign last_block = &fcnt;

	assign mem_done = !ccif.dwait;
	// second word of the block in the *2 states
	assign mem_blk = DBLK_W'(state inside {WB2, FETCH2, FLUSH2});

	// hits only count while idle, never mid-fill
	assign dcif.dhit = (state == IDLE) && req_valid && hit;
	assign dcif.dmemload = cache[req.idx][hit_way].data[req.blkoff];
	assign dcif.flushed = (state == FLUSHED);

	always_comb begin
		next_state = state;
		fcnt_next = fcnt;
		case (state)
			IDLE: begin
				if (dcif.halt) begin
					next_state = FLUSH1;
				end else if (req_valid && !hit) begin
					next_state = victim.dirty ? WB1 : FETCH1;
				end
			end
			WB1: if (mem_done) next_state = WB2;
			WB2: if (mem_done) next_state = FETCH1;
			FETCH1: if (mem_done) next_state = FETCH2;
			FETCH2: if (mem_done) next_state = IDLE;
			FLUSH1: begin
				if (fblk.dirty) begin
					if (mem_done) next_state = FLUSH2;
				end else if (last_block) begin
					next_state = FLUSHED;
				end else begin
					// clean block, skip without a memory access
					fcnt_next = fcnt + 1'b1;
				end
			end
			FLUSH2: begin
				if (mem_done) begin
					if (last_block) begin
						next_state = FLUSHED;
					end else begin
						next_state = FLUSH1;
						fcnt_next = fcnt + 1'b1;
					end
				end
			end
			default: next_state = state;
		endcase
	end

	// memory request from the current state
	always_comb begin
		ccif.dREN = 1'b0;
		ccif.dWEN = 1'b0;
		ccif.daddr = {req.tag, req.idx, mem_blk, {DBYT_W{1'b0}}};
		ccif.dstore = victim.data[mem_blk];
		case (state)
			WB1, WB2: begin
				ccif.dWEN = 1'b1;
				ccif.daddr = {victim.tag, req.idx, mem_blk, {DBYT_W{1'b0}}};
			end
			FETCH1, FETCH2: ccif.dREN = 1'b1;
			FLUSH1, FLUSH2: begin
				ccif.dWEN = fblk.dirty;
				ccif.daddr = {fblk.tag, fset, mem_blk, {DBYT_W{1'b0}}};
				ccif.dstore = fblk.data[mem_blk];
			end
			default: ccif.dREN = 1'b0;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			fcnt <= '0;
			mru <= '0;
			cache <= '0;
		end else begin
			state <= next_state;
			fcnt <= fcnt_next;
			case (state)
				IDLE: begin
					if (dcif.dhit) begin
						mru[req.idx] <= hit_way;
						if (dcif.dmemWEN) begin
							cache[req.idx][hit_way].data[req.blkoff] <= dcif.dmemstore;
							cache[req.idx][hit_way].dirty <= 1'b1;
						end
					end
				end
				WB2: begin
					if (mem_done) cache[req.idx][victim_way].dirty <= 1'b0;
				end
				FETCH1: begin
					// line stays invalid until the second word lands
					if (mem_done) begin
						cache[req.idx][victim_way].tag <= req.tag;
						cache[req.idx][victim_way].data[0] <= ccif.dload;
						cache[req.idx][victim_way].valid <= 1'b0;
						cache[req.idx][victim_way].dirty <= 1'b0;
					end
				end
				FETCH2: begin
					if (mem_done) begin
						cache[req.idx][victim_way].data[1] <= ccif.dload;
						cache[req.idx][victim_way].valid <= 1'b1;
						mru[req.idx] <= victim_way;
					end
				end
				FLUSH2: begin
					if (mem_done) cache[fset][fway].dirty <= 1'b0;
				end
				default: mru <= mru;
			endcase
		end
	end

endmodule

/* src/memory_control.sv */
// fixed MEM_WAIT wait states per word; only the low address bits select a word, array is not reset
`timescale 1ns/10ps

module memory_control (
	input logic CLK,
	input logic nRST,
	cache_control_if.mem ccif
);
	import cpu_types_pkg::*;
	import cache_cfg_pkg::*;

	// zeroed at start of simulation, kept across nRST
	word_t mem [0:(1 << MEM_ADDR_W)-1] = '{default: '0};

	logic [WAIT_CNT_W-1:0] wait_cnt;
	logic req;
	logic done;
	logic [MEM_ADDR_W-1:0] widx;

	assign req = ccif.dREN | ccif.dWEN;
	assign done = req && (wait_cnt == WAIT_CNT_W'(MEM_WAIT));

	// word address, byte offset dropped
	assign widx = ccif.daddr[MEM_ADDR_W+1:2];

	assign ccif.dwait = !done;
	assign ccif.dload = mem[widx];

	// restarts after each completed word and whenever the bus is idle
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wait_cnt <= '0;
		end else if (!req || done) begin
			wait_cnt <= '0;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (done && ccif.dWEN) begin
			mem[widx] <= ccif.dstore;
		end
	end

endmodule

/* verif/cache_system_tb.sv */
// random cache test; assumes memory starts zeroed and keeps its contents across reset, addresses < 1 KB
`timescale 1ns/10ps

module cache_system_tb;
	import cpu_types_pkg::*;

	localparam int HALF = 20;
	localparam int REQ_LIMIT = 64;
	localparam int FLUSH_LIMIT = 400;

	logic CLK, nRST, dmemREN, dmemWEN, halt, dhit, flushed;
	word_t dmemaddr, dmemstore, dmemload, got;
	word_t model [0:255];
	logic [255:0] written;
	logic [31:0] lfsr = 32'hafd2_53a2;
	logic first, stop_run;
	int test_errors, passed, failed, waited;

	cache_system uut (
		.CLK(CLK), .nRST(nRST), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
		.dmemaddr(dmemaddr), .dmemstore(dmemstore), .dmemload(dmemload),
		.dhit(dhit), .flushed(flushed)
	);

	initial begin
		CLK = 1'b0;
		forever #HALF CLK = ~CLK;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic word_t addr_of(input logic [7:0] widx);
		return {22'd0, widx, 2'b00};
	endfunction

	task automatic apply_reset();
		@(negedge CLK);
		nRST = 1'b0;
		halt = 1'b0;
		repeat (3) @(negedge CLK);
		nRST = 1'b1;
	endtask

	// holds one request until dhit; called and returns on a falling edge
	task automatic access(input logic wr, input word_t addr, input word_t wdata);
		int n;
		n = 0;
		if (!stop_run) begin
			dmemREN = !wr;
			dmemWEN = wr;
			dmemaddr = addr;
			dmemstore = wdata;
			#1;
			first = dhit;
			while (!dhit && n < REQ_LIMIT) begin
				@(negedge CLK);
				#1;
				n++;
			end
			if (dhit) begin
				got = dmemload;
				if (wr) begin
					model[addr[9:2]] = wdata;
					written[addr[9:2]] = 1'b1;
				end
			end else begin
				$display("no dhit within %0d cycles for address %h", REQ_LIMIT, addr);
				stop_run = 1'b1;
				test_errors++;
			end
			@(negedge CLK);
			dmemREN = 1'b0;
			dmemWEN = 1'b0;
		end
	endtask

	task automatic check_read(input word_t addr);
		access(1'b0, addr, '0);
		if (!stop_run && got !== model[addr[9:2]]) begin
			$display("error at %0t: read %h gave %h, expected %h", $time, addr, got,
				model[addr[9:2]]);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("%s: passed", name);
			passed++;
		end else begin
			$display("%s: failed with %0d errors", name, test_errors);
			failed++;
		end
		test_errors = 0;
	endtask

	initial begin
		logic [7:0] idx;
		nRST = 1'b0;
		{dmemREN, dmemWEN, halt, dmemaddr, dmemstore} = '0;
		{written, stop_run, test_errors, passed, failed} = '0;
		foreach (model[i]) model[i] = '0;
		apply_reset();
		repeat (4) check_read(addr_of(8'(take_bits(8))));
		finish_test("untouched reads");
		idx = 8'(take_bits(8));
		access(1'b1, addr_of(idx), take_bits(32));
		check_read(addr_of(idx));
		access(1'b0, addr_of(idx), '0);
		if (!stop_run && (!first || got !== model[idx])) begin
			$display("error at %0t: repeated read of %h missed or gave %h", $time,
				addr_of(idx), got);
			test_errors++;
		end
		finish_test("write then read");
		// same set index, three tags in a row
		idx = 8'(take_bits(8));
		for (int t = 0; t < 3; t++) access(1'b1, addr_of(idx + 8'(t * 16)), take_bits(32));
		for (int t = 0; t < 3; t++) check_read(addr_of(idx + 8'(t * 16)));
		finish_test("conflict eviction");
		for (int k = 0; k < 300; k++) begin
			if (take_bits(1) == 1) access(1'b1, addr_of(8'(take_bits(8))), take_bits(32));
			else check_read(addr_of(8'(take_bits(8))));
		end
		finish_test("random mix");
		halt = 1'b1;
		waited = 0;
		while (!stop_run && !flushed && waited < FLUSH_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (!stop_run && !flushed) begin
			$display("flushed did not rise within %0d cycles", FLUSH_LIMIT);
			stop_run = 1'b1;
			test_errors++;
		end
		for (int c = 0; c < 20 && !stop_run; c++) begin
			@(negedge CLK);
			if (!flushed) begin
				$display("error at %0t: flushed fell while halt was held", $time);
				test_errors++;
			end
		end
		apply_reset();
		for (int w = 0; w < 256; w++) if (written[w]) check_read(addr_of(8'(w)));
		finish_test("flush and reset");
		$display("tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* verif/dcache_assertions.sv */
// checks the memory bus and datapath levels inside dcache; assumes one requester on the memory bus
`timescale 1ns/10ps

module dcache_assertions (
	input logic CLK,
	input logic nRST,
	input logic dren,
	input logic dwen,
	input logic dwait,
	input cpu_types_pkg::word_t daddr,
	input logic dhit,
	input logic flushed
);

	// one memory command at a time
	excl_cmd: assert property (@(posedge CLK) disable iff (!nRST) !(dren && dwen))
		else $error("dREN and dWEN high in the same cycle");

	// a stalled request keeps its address
	hold_addr: assert property (@(posedge CLK) disable iff (!nRST)
		(dren || dwen) && dwait |=> (dren || dwen) && $stable(daddr))
		else $error("daddr changed while dwait was high");

	no_hit_flushed: assert property (@(posedge CLK) disable iff (!nRST) flushed |-> !dhit)
		else $error("dhit high after the flush finished");

	// only reset clears flushed
	keep_flushed: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
		else $error("flushed fell without reset");

endmodule

bind dcache dcache_assertions u_assertions (
	.CLK(CLK),
	.nRST(nRST),
	.dren(ccif.dREN),
	.dwen(ccif.dWEN),
	.dwait(ccif.dwait),
	.daddr(ccif.daddr),
	.dhit(dcif.dhit),
	.flushed(dcif.flushed)
);

/* vlog.f */
src/cpu_types_pkg.sv
src/cache_cfg_pkg.sv
src/datapath_cache_if.sv
src/cache_control_if.sv
src/dcache.sv
src/memory_control.sv
src/cache_system.sv
verif/dcache_assertions.sv
verif/cache_system_tb.sv
